/* l2_bus_pkg.sv */
`default_nettype none

package l2_bus_pkg;

    localparam int LINE_W     = 256;
    localparam int BEAT_W     = 64;
    localparam int BEATS      = LINE_W / BEAT_W;    // Beats per cache line
    localparam int LINE_BYTES = LINE_W / 8;
    localparam int BEAT_BYTES = BEAT_W / 8;

    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [LINE_BYTES-1:0] line_strb_t;
    typedef logic [BEAT_W-1:0]     beat_t;
    typedef logic [BEAT_BYTES-1:0] beat_strb_t;
    typedef logic [31:0]           addr_t;          // Byte address
    typedef logic [2:0]            size_t;          // log2 of bytes per transfer
    typedef logic [7:0]            len_t;           // Beats in burst minus one
    typedef logic [1:0]            resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } serdes_state_t;

    typedef enum logic [1:0] {
        SR_IDLE,
        SR_READ,
        SR_WRITE,
        SR_RESP
    } sram_state_t;

    // Request size to burst length, anything up to 8 bytes is one beat
    function automatic len_t size_to_len(input size_t size);
        len_t len;
        case (size)
            3'd4:    len = 8'd1;                        // 16 bytes in two beats
            3'd5:    len = 8'd3;                        // Whole line
            default: len = 8'd0;
        endcase
        return len;
    endfunction

    // Beat size never exceeds the 8-byte bus
    function automatic size_t size_to_beat_size(input size_t size);
        size_t beat_size;
        if (size >= 3'd3) begin
            beat_size = 3'd3;
        end else begin
            beat_size = size;
        end
        return beat_size;
    endfunction

endpackage

`default_nettype wire

/* burst_bus_if.sv */
`default_nettype none

interface burst_bus_if;
    import l2_bus_pkg::*;

    // Read address
    logic       ar_valid;
    logic       ar_ready;
    addr_t      ar_addr;
    len_t       ar_len;
    size_t      ar_size;
    // Write address
    logic       aw_valid;
    logic       aw_ready;
    addr_t      aw_addr;
    len_t       aw_len;
    size_t      aw_size;
    // Write data
    logic       w_valid;
    logic       w_ready;
    beat_t      w_data;
    beat_strb_t w_strb;
    logic       w_last;
    // Read data, always accepted by the master
    logic       r_valid;
    beat_t      r_data;
    resp_t      r_resp;
    logic       r_last;
    // Write response
    logic       b_valid;
    logic       b_ready;
    resp_t      b_resp;

    modport master (
        output ar_valid, ar_addr, ar_len, ar_size,
        output aw_valid, aw_addr, aw_len, aw_size,
        output w_valid, w_data, w_strb, w_last,
        output b_ready,
        input  ar_ready, aw_ready, w_ready,
        input  r_valid, r_data, r_resp, r_last,
        input  b_valid, b_resp
    );

    modport slave (
        input  ar_valid, ar_addr, ar_len, ar_size,
        input  aw_valid, aw_addr, aw_len, aw_size,
        input  w_valid, w_data, w_strb, w_last,
        input  b_ready,
        output ar_ready, aw_ready, w_ready,
        output r_valid, r_data, r_resp, r_last,
        output b_valid, b_resp
    );

endinterface

`default_nettype wire

/* line_serdes.sv */
`default_nettype none

module line_serdes (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    // Line read request
    input  logic                   i_ar_valid,
    input  l2_bus_pkg::addr_t      i_ar_addr,
    input  l2_bus_pkg::size_t      i_ar_size,
    output logic                   o_ar_ready,
    // Line write request
    input  logic                   i_aw_valid,
    input  l2_bus_pkg::addr_t      i_aw_addr,
    input  l2_bus_pkg::size_t      i_aw_size,
    input  l2_bus_pkg::line_t      i_w_data,
    input  l2_bus_pkg::line_strb_t i_w_strb,
    output logic                   o_aw_ready,
    output logic                   o_w_ready,
    // Assembled read line
    output logic                   o_r_valid,
    output l2_bus_pkg::line_t      o_r_data,
    output l2_bus_pkg::resp_t      o_r_resp,
    // Write response
    input  logic                   i_b_ready,
    output logic                   o_b_valid,
    output l2_bus_pkg::resp_t      o_b_resp,
    burst_bus_if.master            mem
);
    import l2_bus_pkg::*;

    serdes_state_t    state, state_nxt;
    line_t            line_q, line_nxt;      // Write shift register or read assembly
    line_strb_t       strb_q, strb_nxt;
    logic [BEATS-1:0] rsel, rsel_nxt;        // One-hot slot for the next read beat
    len_t             rem, rem_nxt;          // Beats left after the current one
    logic             b_wait, b_wait_nxt;
    logic             idle;
    logic             ar_req;
    logic             aw_req;
    logic             last_beat;
    line_t            line_merged;

    assign idle      = (state == ST_IDLE);
    assign ar_req    = i_ar_valid && idle;
    assign aw_req    = i_aw_valid && !i_ar_valid && idle;   // Reads win a tie
    assign last_beat = (rem == '0);

    // Incoming beat placed into its slot of the line
    always_comb begin
        line_merged = line_q;
        for (int i = 0; i < BEATS; i++) begin
            if (rsel[i]) begin
                line_merged[i*BEAT_W +: BEAT_W] = mem.r_data;
            end
        end
    end

    always_comb begin
        state_nxt  = state;
        line_nxt   = line_q;
        strb_nxt   = strb_q;
        rsel_nxt   = rsel;
        rem_nxt    = rem;
        b_wait_nxt = b_wait;

        if (mem.b_valid && i_b_ready) begin
            b_wait_nxt = 1'b0;
        end

        case (state)
            ST_IDLE: begin
                if (ar_req && mem.ar_ready) begin
                    state_nxt = ST_READ;
                    line_nxt  = '0;                     // Untransferred beats read as zero
                    rsel_nxt  = {{(BEATS-1){1'b0}}, 1'b1};
                    rem_nxt   = size_to_len(i_ar_size);
                end else if (aw_req && mem.aw_ready) begin
                    state_nxt = ST_WRITE;
                    line_nxt  = i_w_data;
                    strb_nxt  = i_w_strb;
                    rem_nxt   = size_to_len(i_aw_size);
                end
            end
            ST_READ: begin
                if (mem.r_valid) begin
                    line_nxt = line_merged;
                    rsel_nxt = {rsel[BEATS-2:0], 1'b0};
                    if (last_beat) begin
                        state_nxt = ST_IDLE;
                    end else begin
                        rem_nxt = rem - 1'b1;
                    end
                end
            end
            ST_WRITE: begin
                if (mem.w_ready) begin
                    // Next beat moves down to the low end
                    line_nxt = {{BEAT_W{1'b0}}, line_q[LINE_W-1:BEAT_W]};
                    strb_nxt = {{BEAT_BYTES{1'b0}}, strb_q[LINE_BYTES-1:BEAT_BYTES]};
                    if (last_beat) begin
                        state_nxt  = ST_IDLE;
                        b_wait_nxt = 1'b1;
                    end else begin
                        rem_nxt = rem - 1'b1;
                    end
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state  <= ST_IDLE;
            rsel   <= '0;
            rem    <= '0;
            b_wait <= 1'b0;
        end else begin
            state  <= state_nxt;
            rsel   <= rsel_nxt;
            rem    <= rem_nxt;
            b_wait <= b_wait_nxt;
        end
    end

    always_ff @(posedge i_clk) begin
        line_q <= line_nxt;
        strb_q <= strb_nxt;
    end

    // Narrow bus requests
    assign mem.ar_valid = ar_req;
    assign mem.ar_addr  = i_ar_addr;
    assign mem.ar_len   = size_to_len(i_ar_size);
    assign mem.ar_size  = size_to_beat_size(i_ar_size);
    assign mem.aw_valid = aw_req;
    assign mem.aw_addr  = i_aw_addr;
    assign mem.aw_len   = size_to_len(i_aw_size);
    assign mem.aw_size  = size_to_beat_size(i_aw_size);
    assign mem.w_valid  = (state == ST_WRITE);
    assign mem.w_data   = line_q[BEAT_W-1:0];
    assign mem.w_strb   = strb_q[BEAT_BYTES-1:0];
    assign mem.w_last   = (state == ST_WRITE) && last_beat;
    assign mem.b_ready  = i_b_ready;

    // Cache side
    assign o_ar_ready = mem.ar_ready && idle;
    assign o_aw_ready = mem.aw_ready && idle && !i_ar_valid;
    assign o_w_ready  = (state == ST_WRITE) && mem.w_ready && last_beat;
    assign o_r_valid  = (state == ST_READ) && mem.r_valid && mem.r_last;
    assign o_r_data   = line_merged;
    assign o_r_resp   = mem.r_resp;
    assign o_b_valid  = mem.b_valid && b_wait;
    assign o_b_resp   = mem.b_resp;

    // Memory only returns beats while a read burst is open here
    a_r_in_read: assert property (@(posedge i_clk) disable iff (!i_nrst)
        mem.r_valid |-> state == ST_READ);

    // Memory closes the burst on the same beat as the local count
    a_w_last: assert property (@(posedge i_clk) disable iff (!i_nrst)
        mem.w_valid && mem.w_ready && last_beat |=> mem.b_valid);

endmodule

`default_nettype wire

/* burst_sram.sv */
`default_nettype none

module burst_sram #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic       i_clk,
    input  logic       i_nrst,
    burst_bus_if.slave bus
);
    import l2_bus_pkg::*;

    localparam int WORDS = 2 ** DEPTH_LOG2;

    beat_t                 mem_array [WORDS];
    sram_state_t           state;
    addr_t                 addr;        // Byte address of the current beat
    len_t                  cnt;         // Beats left after the current one
    beat_strb_t            lanes;       // Byte lanes covered by the transfer size
    logic                  err;         // Sticky out-of-range flag for the write burst
    logic                  in_range;
    logic [DEPTH_LOG2-1:0] word_idx;
    beat_t                 rd_word;
    beat_strb_t            wr_strb;

    // Active byte lanes for a narrow transfer at the given offset
    function automatic beat_strb_t lane_mask(input size_t size, input logic [2:0] offs);
        beat_strb_t m;
        case (size)
            3'd0:    m = 8'h01 << offs;
            3'd1:    m = 8'h03 << {offs[2:1], 1'b0};
            3'd2:    m = 8'h0f << {offs[2], 2'b00};
            default: m = 8'hff;
        endcase
        return m;
    endfunction

    assign in_range = ((addr >> (DEPTH_LOG2 + 3)) == '0);
    assign word_idx = addr[DEPTH_LOG2+2:3];
    assign wr_strb  = bus.w_strb & lanes;

    // Out-of-range reads give zero data
    always_comb begin
        rd_word = '0;
        if (in_range) begin
            for (int b = 0; b < BEAT_BYTES; b++) begin
                if (lanes[b]) begin
                    rd_word[8*b +: 8] = mem_array[word_idx][8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= SR_IDLE;
            addr  <= '0;
            cnt   <= '0;
            lanes <= '0;
            err   <= 1'b0;
        end else begin
            case (state)
                SR_IDLE: begin
                    if (bus.ar_valid) begin
                        state <= SR_READ;
                        addr  <= bus.ar_addr;
                        cnt   <= bus.ar_len;
                        lanes <= lane_mask(bus.ar_size, bus.ar_addr[2:0]);
                    end else if (bus.aw_valid) begin
                        state <= SR_WRITE;
                        addr  <= bus.aw_addr;
                        cnt   <= bus.aw_len;
                        lanes <= lane_mask(bus.aw_size, bus.aw_addr[2:0]);
                        err   <= 1'b0;
                    end
                end
                SR_READ: begin
                    addr <= addr + 32'(BEAT_BYTES);    // Incrementing burst
                    cnt  <= cnt - 1'b1;
                    if (cnt == '0) begin
                        state <= SR_IDLE;
                    end
                end
                SR_WRITE: begin
                    if (bus.w_valid) begin
                        addr <= addr + 32'(BEAT_BYTES);
                        cnt  <= cnt - 1'b1;
                        if (!in_range) begin
                            err <= 1'b1;
                        end
                        if (bus.w_last) begin
                            state <= SR_RESP;
                        end
                    end
                end
                SR_RESP: begin
                    if (bus.b_ready) begin
                        state <= SR_IDLE;               // Response held until taken
                    end
                end
                default: state <= SR_IDLE;
            endcase
        end
    end

    // Array left untouched outside its range
    always_ff @(posedge i_clk) begin
        if (state == SR_WRITE && bus.w_valid && in_range) begin
            for (int b = 0; b < BEAT_BYTES; b++) begin
                if (wr_strb[b]) begin
                    mem_array[word_idx][8*b +: 8] <= bus.w_data[8*b +: 8];
                end
            end
        end
    end

    assign bus.ar_ready = (state == SR_IDLE);
    assign bus.aw_ready = (state == SR_IDLE);
    assign bus.r_valid  = (state == SR_READ);
    assign bus.r_data   = rd_word;
    assign bus.r_resp   = (state == SR_READ && !in_range) ? RESP_SLVERR : RESP_OKAY;
    assign bus.r_last   = (state == SR_READ) && (cnt == '0);
    assign bus.w_ready  = (state == SR_WRITE);
    assign bus.b_valid  = (state == SR_RESP);
    assign bus.b_resp   = err ? RESP_SLVERR : RESP_OKAY;

    // Master never offers both request channels at once
    a_one_req: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(bus.ar_valid && bus.aw_valid));

    // Write beats only follow an accepted write address
    a_w_in_write: assert property (@(posedge i_clk) disable iff (!i_nrst)
        bus.w_valid |-> state == SR_WRITE);

endmodule

`default_nettype wire

/* l2_mem_top.sv */
`default_nettype none

module l2_mem_top #(
    parameter int DEPTH_LOG2 = 8               // 64-bit words in the memory, as log2
) (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    // Line read request
    input  logic                   i_ar_valid,
    input  l2_bus_pkg::addr_t      i_ar_addr,
    input  l2_bus_pkg::size_t      i_ar_size,
    output logic                   o_ar_ready,
    // Line write request
    input  logic                   i_aw_valid,
    input  l2_bus_pkg::addr_t      i_aw_addr,
    input  l2_bus_pkg::size_t      i_aw_size,
    input  l2_bus_pkg::line_t      i_w_data,
    input  l2_bus_pkg::line_strb_t i_w_strb,
    output logic                   o_aw_ready,
    output logic                   o_w_ready,
    // Read line
    output logic                   o_r_valid,
    output l2_bus_pkg::line_t      o_r_data,
    output l2_bus_pkg::resp_t      o_r_resp,
    // Write response
    input  logic                   i_b_ready,
    output logic                   o_b_valid,
    output l2_bus_pkg::resp_t      o_b_resp
);

    burst_bus_if bus_if ();

    // Line to beat conversion
    line_serdes u_serdes (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_ar_valid (i_ar_valid),
        .i_ar_addr  (i_ar_addr),
        .i_ar_size  (i_ar_size),
        .o_ar_ready (o_ar_ready),
        .i_aw_valid (i_aw_valid),
        .i_aw_addr  (i_aw_addr),
        .i_aw_size  (i_aw_size),
        .i_w_data   (i_w_data),
        .i_w_strb   (i_w_strb),
        .o_aw_ready (o_aw_ready),
        .o_w_ready  (o_w_ready),
        .o_r_valid  (o_r_valid),
        .o_r_data   (o_r_data),
        .o_r_resp   (o_r_resp),
        .i_b_ready  (i_b_ready),
        .o_b_valid  (o_b_valid),
        .o_b_resp   (o_b_resp),
        .mem        (bus_if.master)
    );

    // Memory answering the bursts
    burst_sram #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_sram (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .bus    (bus_if.slave)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_nrst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Release away from the rising edge
    initial begin
        o_nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_nrst = 1'b1;
    end

endmodule

`default_nettype wire

/* l2_mem_tb.sv */
`default_nettype none

module l2_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import l2_bus_pkg::*;

    localparam int          DEPTH_LOG2 = 8;
    localparam int          MEM_BYTES  = 8 * (2 ** DEPTH_LOG2);     // 2 KiB
    localparam int          B_HOLD     = 3;                         // Cycles of b_ready low
    localparam logic [31:0] SEED       = 32'hf358_d5c4;

    typedef struct packed {
        logic  is_write;
        addr_t addr;
        size_t size;
        logic  rand_strb;
        logic  b_delay;
        resp_t resp;
    } row_t;

    logic       clk;
    logic       nrst;
    logic       i_ar_valid;
    addr_t      i_ar_addr;
    size_t      i_ar_size;
    logic       o_ar_ready;
    logic       i_aw_valid;
    addr_t      i_aw_addr;
    size_t      i_aw_size;
    line_t      i_w_data;
    line_strb_t i_w_strb;
    logic       o_aw_ready;
    logic       o_w_ready;
    logic       o_r_valid;
    line_t      o_r_data;
    resp_t      o_r_resp;
    logic       i_b_ready;
    logic       o_b_valid;
    resp_t      o_b_resp;

    logic [7:0]  ref_mem [MEM_BYTES];   // Byte model of the SRAM
    row_t        rows [$];
    logic [31:0] lcg_state;
    int          error_count = 0;
    int          cycles      = 0;
    int          cycle_limit = 0;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(2)) u_clk (.o_clk(clk), .o_nrst(nrst));

    l2_mem_top #(.DEPTH_LOG2(DEPTH_LOG2)) UUT (
        .i_clk(clk), .i_nrst(nrst),
        .i_ar_valid(i_ar_valid), .i_ar_addr(i_ar_addr), .i_ar_size(i_ar_size),
        .o_ar_ready(o_ar_ready),
        .i_aw_valid(i_aw_valid), .i_aw_addr(i_aw_addr), .i_aw_size(i_aw_size),
        .i_w_data(i_w_data), .i_w_strb(i_w_strb),
        .o_aw_ready(o_aw_ready), .o_w_ready(o_w_ready),
        .o_r_valid(o_r_valid), .o_r_data(o_r_data), .o_r_resp(o_r_resp),
        .i_b_ready(i_b_ready), .o_b_valid(o_b_valid), .o_b_resp(o_b_resp)
    );

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_line(input string name, input line_t actual, input line_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input resp_t actual, input resp_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // One beat up to 8 bytes, then 16 B in two and a full line in four
    function automatic int beats_for_size(input size_t size);
        if (size == 3'd5) begin
            return 4;
        end else if (size == 3'd4) begin
            return 2;
        end
        return 1;
    endfunction

    // Byte lanes of the naturally aligned chunk that holds the address
    function automatic logic [7:0] beat_lanes(input size_t size, input logic [2:0] offs);
        logic [7:0] m;
        m = '0;
        for (int b = 0; b < 8; b++) begin
            if (size >= 3'd3 || (b >> size) == (offs >> size)) begin
                m[b] = 1'b1;
            end
        end
        return m;
    endfunction

    task automatic ref_write(input addr_t addr, input size_t size, input line_t data,
                             input line_strb_t strb);
        logic [7:0]  lanes;
        logic [31:0] wa;
        lanes = beat_lanes(size, addr[2:0]);
        for (int k = 0; k < beats_for_size(size); k++) begin
            wa = ((addr >> 3) + k) << 3;
            if (wa < MEM_BYTES) begin                   // Out of range leaves memory alone
                for (int b = 0; b < 8; b++) begin
                    if (lanes[b] && strb[8*k+b]) begin
                        ref_mem[wa+b] = data[64*k+8*b +: 8];
                    end
                end
            end
        end
    endtask

    // Beat k lands at bit 64k, lanes and beats not moved stay zero
    function automatic line_t expected_line(input addr_t addr, input size_t size);
        line_t       l;
        logic [7:0]  lanes;
        logic [31:0] wa;
        l = '0;
        lanes = beat_lanes(size, addr[2:0]);
        for (int k = 0; k < beats_for_size(size); k++) begin
            wa = ((addr >> 3) + k) << 3;
            for (int b = 0; b < 8; b++) begin
                if (wa < MEM_BYTES && lanes[b]) begin
                    l[64*k+8*b +: 8] = ref_mem[wa+b];
                end
            end
        end
        return l;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
    endtask

    task automatic check_idle();
        check_bit("o_ar_ready", o_ar_ready, 1'b1);
        check_bit("o_aw_ready", o_aw_ready, 1'b1);
        check_bit("o_r_valid", o_r_valid, 1'b0);
        check_bit("o_w_ready", o_w_ready, 1'b0);
        check_bit("o_b_valid", o_b_valid, 1'b0);
    endtask

    task automatic read_line(input addr_t addr, input size_t size, input resp_t exp_resp);
        line_t exp_line;
        int    nb;
        nb = beats_for_size(size);
        exp_line = expected_line(addr, size);
        next_cycle();
        i_ar_valid = 1'b1;
        i_ar_addr  = addr;
        i_ar_size  = size;
        #1;
        while (!o_ar_ready) begin
            next_cycle();
            #1;
        end
        // Handshake on the coming edge, line due nb cycles later
        for (int i = 1; i <= nb; i++) begin
            next_cycle();
            i_ar_valid = 1'b0;
            #1;
            check_bit("o_r_valid", o_r_valid, i == nb);
        end
        check_line("o_r_data", o_r_data, exp_line);
        check_resp("o_r_resp", o_r_resp, exp_resp);
        next_cycle();
        #1;
        check_idle();
    endtask

    task automatic write_line(input addr_t addr, input size_t size, input logic rand_strb,
                              input logic b_delay, input resp_t exp_resp);
        line_t      data;
        line_strb_t strb;
        int         nb;
        nb = beats_for_size(size);
        for (int i = 0; i < LINE_W / 32; i++) begin
            data[32*i +: 32] = lcg_next();
        end
        strb = rand_strb ? lcg_next() : '1;
        ref_write(addr, size, data, strb);
        next_cycle();
        i_aw_valid = 1'b1;
        i_aw_addr  = addr;
        i_aw_size  = size;
        i_w_data   = data;
        i_w_strb   = strb;
        i_b_ready  = !b_delay;
        #1;
        while (!o_aw_ready) begin
            next_cycle();
            #1;
        end
        for (int i = 1; i <= nb; i++) begin
            next_cycle();
            i_aw_valid = 1'b0;
            #1;
            check_bit("o_w_ready", o_w_ready, i == nb);   // Pulse on the last beat
        end
        next_cycle();
        #1;
        check_bit("o_b_valid", o_b_valid, 1'b1);
        check_resp("o_b_resp", o_b_resp, exp_resp);
        if (b_delay) begin
            for (int i = 0; i < B_HOLD; i++) begin
                check_bit("o_ar_ready", o_ar_ready, 1'b0);
                check_bit("o_aw_ready", o_aw_ready, 1'b0);
                next_cycle();
                #1;
                check_bit("o_b_valid", o_b_valid, 1'b1);
            end
            next_cycle();
            i_b_ready = 1'b1;
            #1;
            check_bit("o_b_valid", o_b_valid, 1'b1);
            check_resp("o_b_resp", o_b_resp, exp_resp);
        end
        next_cycle();
        #1;
        check_idle();
    endtask

    task automatic add_row(input logic is_write, input addr_t addr, input size_t size,
                           input logic rand_strb, input logic b_delay, input resp_t resp);
        row_t r;
        r.is_write  = is_write;
        r.addr      = addr;
        r.size      = size;
        r.rand_strb = rand_strb;
        r.b_delay   = b_delay;
        r.resp      = resp;
        rows.push_back(r);
    endtask

    // Write, address, size, random strobes, delayed b_ready, response
    task automatic build_table();
        add_row(1'b1, 32'h000, 3'd5, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b0, 32'h000, 3'd5, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b1, 32'h020, 3'd5, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b1, 32'h020, 3'd5, 1'b1, 1'b0, RESP_OKAY);
        add_row(1'b0, 32'h020, 3'd5, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b1, 32'h7e0, 3'd5, 1'b0, 1'b0, RESP_OKAY);   // Top line of the memory
        add_row(1'b0, 32'h7e0, 3'd5, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b1, 32'h040, 3'd5, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b1, 32'h043, 3'd0, 1'b1, 1'b0, RESP_OKAY);
        add_row(1'b0, 32'h043, 3'd0, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b0, 32'h046, 3'd1, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b1, 32'h044, 3'd2, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b0, 32'h044, 3'd2, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b1, 32'h048, 3'd3, 1'b1, 1'b0, RESP_OKAY);
        add_row(1'b0, 32'h048, 3'd3, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b1, 32'h050, 3'd4, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b0, 32'h050, 3'd4, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b0, 32'h040, 3'd5, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b1, 32'h800, 3'd5, 1'b0, 1'b0, RESP_SLVERR); // Just past 2 KiB
        add_row(1'b0, 32'h800, 3'd5, 1'b0, 1'b0, RESP_SLVERR);
        add_row(1'b1, 32'h1000, 3'd3, 1'b0, 1'b0, RESP_SLVERR);
        add_row(1'b0, 32'h1000, 3'd2, 1'b0, 1'b0, RESP_SLVERR);
        add_row(1'b1, 32'h020, 3'd5, 1'b1, 1'b1, RESP_OKAY);
        add_row(1'b0, 32'h020, 3'd5, 1'b0, 1'b0, RESP_OKAY);
        add_row(1'b1, 32'h000, 3'd4, 1'b0, 1'b1, RESP_OKAY);
        add_row(1'b0, 32'h000, 3'd5, 1'b0, 1'b0, RESP_OKAY);
    endtask

    initial begin
        row_t r;
        i_ar_valid = 1'b0;
        i_ar_addr  = '0;
        i_ar_size  = '0;
        i_aw_valid = 1'b0;
        i_aw_addr  = '0;
        i_aw_size  = '0;
        i_w_data   = '0;
        i_w_strb   = '0;
        i_b_ready  = 1'b1;
        lcg_state  = SEED;
        build_table();
        cycle_limit = 40 * rows.size() + 100;
        wait (nrst === 1'b1);
        next_cycle();
        #1;
        check_idle();
        foreach (rows[i]) begin
            r = rows[i];
            if (r.is_write) begin
                write_line(r.addr, r.size, r.rand_strb, r.b_delay, r.resp);
            end else begin
                read_line(r.addr, r.size, r.resp);
            end
        end
        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run();
        end
    end

    // Watchdog over the whole run
    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
        abort_run();
    end

endmodule

`default_nettype wire

/* compile.f */
l2_bus_pkg.sv
burst_bus_if.sv
line_serdes.sv
burst_sram.sv
l2_mem_top.sv
tb_clock_gen.sv
l2_mem_tb.sv
